// ==== project.f ====
rtl/trellisPkg.sv
rtl/metricDecay.sv
rtl/soqpskAcs.sv
rtl/survivorSelect.sv
rtl/soqpskTrellis.sv
tests/trellisChecks_assert.sv
tests/trellisChecker.sv
tests/trellisTb.sv

// ==== rtl/metricDecay.sv ====
`timescale 1ns/100ps

// Scales the survivor metric by the decay factor so old symbols fade out.
// The multiply is registered, which gives the one symbol of metric latency
module metricDecay (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  ce,
   input  logic [trellisPkg::METRIC_BITS-1:0]    survivor,
   input  logic [trellisPkg::DECAY_BITS-1:0]     decayFactor,
   output logic [trellisPkg::DECAY_OUT_BITS-1:0] decayOut
);
   import trellisPkg::*;

   localparam int PROD_BITS = METRIC_BITS + DECAY_BITS;
   localparam int DROP_BITS = PROD_BITS - DECAY_OUT_BITS; // fraction bits below the slice

   logic [PROD_BITS-1:0] product;

   // both operands unsigned, the full 20-bit product is formed before slicing
   assign product = survivor * decayFactor;

   always_ff @(posedge clk) begin
      if (reset) begin
         decayOut <= '0;
      end else if (ce) begin
         decayOut <= product[PROD_BITS-1:DROP_BITS]; // factor 128 is about one half
      end
   end

endmodule

// ==== rtl/soqpskAcs.sv ====
`timescale 1ns/100ps

// Add-compare-select for one state of the two-state SOQPSK trellis.
// Candidate 1 comes from state 0, candidate 2 from state 1
module soqpskAcs #(
   parameter int NORM_OFFSET = 512
) (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               symEn,
   input  logic [trellisPkg::DECAY_BITS-1:0]  decayFactor,
   input  logic                               normalize,
   input  logic [trellisPkg::METRIC_BITS-1:0] candMet1,
   input  logic [trellisPkg::METRIC_BITS-1:0] candMet2,
   input  trellisPkg::rotPointT               branch1,
   input  trellisPkg::rotPointT               branch2,
   output trellisPkg::acsStateT               state
);
   import trellisPkg::*;

   logic [METRIC_BITS-1:0]    sum1;
   logic [METRIC_BITS-1:0]    sum2;
   logic                      secondWins;
   logic [METRIC_BITS-1:0]    chosenSum;
   logic [METRIC_BITS-1:0]    normDiff;
   logic [METRIC_BITS-1:0]    survivor;
   rotPointT                  chosenPoint;
   logic [DECAY_OUT_BITS-1:0] decayOut;
   logic [METRIC_BITS-1:0]    metricRounded;
   logic                      normFlag;
   logic                      selReg;
   rotPointT                  pointReg;

   // branch metric is the top MF_BITS of the real part, taken as signed
   function automatic logic [METRIC_BITS-1:0] branchSum(
      input logic [METRIC_BITS-1:0] met,
      input rotPointT               pt
   );
      logic [MF_BITS-1:0] mf;
      mf = pt.re[ROT_BITS-1 -: MF_BITS];
      return met + {{(METRIC_BITS-MF_BITS){mf[MF_BITS-1]}}, mf};
   endfunction

   assign sum1 = branchSum(candMet1, branch1);
   assign sum2 = branchSum(candMet2, branch2);

   // on a tie the first candidate stays
   assign secondWins = $signed(sum2) > $signed(sum1);

   assign chosenSum   = secondWins ? sum2 : sum1;
   assign chosenPoint = secondWins ? branch2 : branch1;

   assign normDiff = chosenSum - METRIC_BITS'(NORM_OFFSET);

   // both states see the same normalize level, so their metrics shift together
   // and the comparison in the survivor selector is unaffected
   always_comb begin
      if (!normalize) begin
         survivor = chosenSum;
      end else if (normDiff[METRIC_BITS-1]) begin
         survivor = '0; // sum was below the offset
      end else begin
         survivor = normDiff;
      end
   end

   metricDecay decay (
      .clk         (clk),
      .reset       (reset),
      .ce          (symEn),
      .survivor    (survivor),
      .decayFactor (decayFactor),
      .decayOut    (decayOut)
   );

   // drop the rounding bit and add it back in, which rounds half up
   assign metricRounded = decayOut[DECAY_OUT_BITS-1:1] + METRIC_BITS'(decayOut[0]);

   // 01 in the top bits means the metric is heading for the sign bit
   assign normFlag = decayOut[DECAY_OUT_BITS-1 -: 2] == 2'b01;

   always_ff @(posedge clk) begin
      if (reset) begin
         selReg   <= 1'b0;
         pointReg <= '0;
      end else if (symEn) begin
         selReg   <= ~secondWins;
         pointReg <= chosenPoint;
      end
   end

   assign state = '{
      metric:    metricRounded,
      sel:       selReg,
      point:     pointReg,
      normalize: normFlag
   };

endmodule

// ==== rtl/soqpskTrellis.sv ====
`timescale 1ns/100ps

// Two-state SOQPSK trellis detector core. One ACS unit per state, metrics fed
// back crosswise, then the survivor selector forms the hard decision
module soqpskTrellis #(
   parameter int NORM_OFFSET = 512
) (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               symEn,
   input  logic [trellisPkg::DECAY_BITS-1:0]  decayFactor,
   input  trellisPkg::branchSetT              branches,
   output logic                               decision,
   output trellisPkg::rotPointT               outPoint,
   output logic                               decisionStrobe,
   output logic [trellisPkg::METRIC_BITS-1:0] metric0,
   output logic [trellisPkg::METRIC_BITS-1:0] metric1
);
   import trellisPkg::*;

   acsStateT acsOut0;
   acsStateT acsOut1;
   logic     normalize;

   // state 0 is reached from state 0 or from state 1
   soqpskAcs #(.NORM_OFFSET(NORM_OFFSET)) acsState0 (
      .clk         (clk),
      .reset       (reset),
      .symEn       (symEn),
      .decayFactor (decayFactor),
      .normalize   (normalize),
      .candMet1    (acsOut0.metric),
      .candMet2    (acsOut1.metric),
      .branch1     (branches.from0To0),
      .branch2     (branches.from1To0),
      .state       (acsOut0)
   );

   soqpskAcs #(.NORM_OFFSET(NORM_OFFSET)) acsState1 (
      .clk         (clk),
      .reset       (reset),
      .symEn       (symEn),
      .decayFactor (decayFactor),
      .normalize   (normalize),
      .candMet1    (acsOut0.metric),
      .candMet2    (acsOut1.metric),
      .branch1     (branches.from0To1),
      .branch2     (branches.from1To1),
      .state       (acsOut1)
   );

   survivorSelect selector (
      .clk            (clk),
      .reset          (reset),
      .symEn          (symEn),
      .state0         (acsOut0),
      .state1         (acsOut1),
      .decision       (decision),
      .outPoint       (outPoint),
      .decisionStrobe (decisionStrobe),
      .normalize      (normalize)
   );

   assign metric0 = acsOut0.metric; // soft-output logic downstream reads both metrics
   assign metric1 = acsOut1.metric;

endmodule

// ==== rtl/survivorSelect.sv ====
`timescale 1ns/100ps

// Picks the better of the two trellis states one cycle after the ACS update
// and hands out its select bit as the hard decision
module survivorSelect (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 symEn,
   input  trellisPkg::acsStateT state0,
   input  trellisPkg::acsStateT state1,
   output logic                 decision,
   output trellisPkg::rotPointT outPoint,
   output logic                 decisionStrobe,
   output logic                 normalize
);
   import trellisPkg::*;

   logic     symEnD;     // ACS registers hold the new symbol in this cycle
   logic     pickState1;
   acsStateT winner;

   // metrics are non-negative after saturation, so compare them unsigned.
   // State 0 keeps ties
   assign pickState1 = state1.metric > state0.metric;
   assign winner     = pickState1 ? state1 : state0;

   always_ff @(posedge clk) begin
      if (reset) begin
         symEnD         <= 1'b0;
         decisionStrobe <= 1'b0;
      end else begin
         symEnD         <= symEn;
         decisionStrobe <= symEnD; // single pulse, symEn is never back to back
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         decision <= 1'b0;
         outPoint <= '0;
      end else if (symEnD) begin
         decision <= winner.sel;
         outPoint <= winner.point;
      end
   end

   // either state close to overflow pulls both down on the next symbol
   assign normalize = state0.normalize | state1.normalize;

endmodule

// ==== rtl/trellisPkg.sv ====
package trellisPkg;

   // rotated matched-filter output, one real and one imaginary part per branch
   localparam int ROT_BITS = 10;

   // only the upper bits of the real part enter the metric adder
   localparam int MF_BITS = 8;

   // four guard bits above the branch metric keep the accumulator from wrapping
   localparam int METRIC_BITS = MF_BITS + 4;

   localparam int DECAY_BITS = 8;

   // registered multiplier slice is one bit wider than the metric, the LSB rounds
   localparam int DECAY_OUT_BITS = METRIC_BITS + 1;

   typedef struct packed {
      logic [ROT_BITS-1:0] re;
      logic [ROT_BITS-1:0] im;
   } rotPointT;

   // the four transitions of the two-state trellis for one symbol
   typedef struct packed {
      rotPointT from0To0;
      rotPointT from1To0;
      rotPointT from0To1;
      rotPointT from1To1;
   } branchSetT;

   typedef struct packed {
      logic [METRIC_BITS-1:0] metric;    // decayed survivor metric
      logic                   sel;       // high when the first candidate survived
      rotPointT               point;     // point of the surviving branch
      logic                   normalize; // metric has grown into the top quarter
   } acsStateT;

endpackage

// ==== tests/trellisChecker.sv ====
`timescale 1ns/100ps

// Watches the detector outputs and compares each decision with its expected line
module trellisChecker (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               symEn,
   input  logic                               decision,
   input  trellisPkg::rotPointT               outPoint,
   input  logic                               decisionStrobe,
   input  logic [trellisPkg::METRIC_BITS-1:0] metric0,
   input  logic [trellisPkg::METRIC_BITS-1:0] metric1,
   input  logic                               expDecision,
   input  trellisPkg::rotPointT               expPoint,
   input  logic [trellisPkg::METRIC_BITS-1:0] expMetric0,
   input  logic [trellisPkg::METRIC_BITS-1:0] expMetric1,
   output int                                 errorCount,
   output int                                 strobeCount
);
   import trellisPkg::*;

   logic seenSym;
   logic pending;  // a symbol was strobed and its decision is still due
   int   age;

   initial begin
      errorCount  = 0;
      strobeCount = 0;
   end

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
         errorCount++;
      end
   endtask

   // sampling on the falling edge keeps clear of the drive and register updates
   always @(negedge clk) begin
      if (reset) begin
         seenSym = 1'b0;
         pending = 1'b0;
         age     = 0;
      end else begin
         if (!seenSym) begin // nothing may move before the first symbol
            checkValue("decisionStrobe", decisionStrobe, 0);
            checkValue("decision", decision, 0);
            checkValue("outPoint", outPoint, 0);
            checkValue("metric0", metric0, 0);
            checkValue("metric1", metric1, 0);
         end
         if (pending) begin
            age++;
            if (decisionStrobe) begin
               if (age != 2) begin
                  $display("decision strobe came %0d cycles after symEn instead of 2", age);
                  errorCount++;
               end
               checkValue("decision", decision, expDecision);
               checkValue("outPoint.re", outPoint.re, expPoint.re);
               checkValue("outPoint.im", outPoint.im, expPoint.im);
               checkValue("metric0", metric0, expMetric0);
               checkValue("metric1", metric1, expMetric1);
               strobeCount++;
               pending = 1'b0;
            end else if (age >= 2) begin
               $display("decision strobe never arrived for the symbol at %0t", $time);
               errorCount++;
               pending = 1'b0;
            end
         end else if (decisionStrobe) begin
            $display("decision strobe at %0t without a symbol", $time);
            errorCount++;
         end
         if (symEn) begin
            seenSym = 1'b1;
            pending = 1'b1;
            age     = 0;
         end
      end
   end

endmodule

// ==== tests/trellisChecks_assert.sv ====
`timescale 1ns/100ps

// Protocol checks on the detector ports, bound into soqpskTrellis
module trellisChecks_assert (
   input logic                               clk,
   input logic                               reset,
   input logic                               symEn,
   input logic                               decisionStrobe,
   input logic [trellisPkg::METRIC_BITS-1:0] metric0,
   input logic [trellisPkg::METRIC_BITS-1:0] metric1
);
   import trellisPkg::*;

   int failCount = 0;

   strobeSingle: assert property (@(posedge clk) disable iff (reset)
      decisionStrobe |=> !decisionStrobe)
      else begin
         $error("decisionStrobe stayed high for more than one cycle");
         failCount++;
      end

   strobeFollows: assert property (@(posedge clk) disable iff (reset)
      symEn |-> ##2 decisionStrobe)
      else begin
         $error("decisionStrobe did not follow symEn after two cycles");
         failCount++;
      end

   // a strobe with no symEn two cycles earlier is just as wrong
   strobeHasCause: assert property (@(posedge clk) disable iff (reset)
      decisionStrobe |-> $past(symEn, 2))
      else begin
         $error("decisionStrobe without a symEn two cycles before");
         failCount++;
      end

   metricsHold: assert property (@(posedge clk) disable iff (reset)
      !$past(symEn) |-> $stable(metric0) && $stable(metric1))
      else begin
         $error("metrics changed without a symbol strobe");
         failCount++;
      end

endmodule

// ==== tests/trellisTb.sv ====
`timescale 1ns/100ps

module trellisTb;
   import trellisPkg::*;

   localparam int MAX_LINES = 64;

   logic                   clk = 1'b0;
   logic                   reset;
   logic                   symEn;
   logic [DECAY_BITS-1:0]  decayFactor;
   branchSetT              branches;
   logic                   decision;
   rotPointT               outPoint;
   logic                   decisionStrobe;
   logic [METRIC_BITS-1:0] metric0;
   logic [METRIC_BITS-1:0] metric1;
   logic                   expDecision;
   rotPointT               expPoint;
   logic [METRIC_BITS-1:0] expMetric0;
   logic [METRIC_BITS-1:0] expMetric1;
   int                     errorCount;
   int                     strobeCount;

   int        fields [MAX_LINES][14]; // one row per symbol, columns as in the data file
   int        nLines = 0;
   int        cycleLimit = 0;
   int        cycles = 0;
   integer    seed = 32;

   always #5 clk = ~clk;

   soqpskTrellis #(.NORM_OFFSET(512)) dut (
      .clk            (clk),
      .reset          (reset),
      .symEn          (symEn),
      .decayFactor    (decayFactor),
      .branches       (branches),
      .decision       (decision),
      .outPoint       (outPoint),
      .decisionStrobe (decisionStrobe),
      .metric0        (metric0),
      .metric1        (metric1)
   );

   bind soqpskTrellis trellisChecks_assert checks (.*);

   trellisChecker scoreboard (.*);

   task automatic readTestData();
      int    fd;
      int    n;
      string lineText;
      fd = $fopen("tests/trellis_testdata.txt", "r");
      if (fd == 0) begin
         $display("cannot open the test data file");
      end else begin
         while (!$feof(fd) && nLines < MAX_LINES) begin
            lineText = "";
            void'($fgets(lineText, fd));
            if (lineText.len() > 2 && lineText[0] != "#") begin
               n = $sscanf(lineText, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  fields[nLines][0], fields[nLines][1], fields[nLines][2],
                  fields[nLines][3], fields[nLines][4], fields[nLines][5],
                  fields[nLines][6], fields[nLines][7], fields[nLines][8],
                  fields[nLines][9], fields[nLines][10], fields[nLines][11],
                  fields[nLines][12], fields[nLines][13]);
               if (n == 14) nLines++;
            end
         end
         $fclose(fd);
      end
   endtask

   // one symbol: strobe for a cycle, then a few idle cycles with the inputs held
   task automatic driveSymbol(input int idx);
      int extra;
      @(posedge clk);
      #1;
      decayFactor       = DECAY_BITS'(fields[idx][0]);
      branches.from0To0 = '{re: ROT_BITS'(fields[idx][1]), im: ROT_BITS'(fields[idx][2])};
      branches.from1To0 = '{re: ROT_BITS'(fields[idx][3]), im: ROT_BITS'(fields[idx][4])};
      branches.from0To1 = '{re: ROT_BITS'(fields[idx][5]), im: ROT_BITS'(fields[idx][6])};
      branches.from1To1 = '{re: ROT_BITS'(fields[idx][7]), im: ROT_BITS'(fields[idx][8])};
      expDecision       = 1'(fields[idx][9]);
      expPoint          = '{re: ROT_BITS'(fields[idx][10]), im: ROT_BITS'(fields[idx][11])};
      expMetric0        = METRIC_BITS'(fields[idx][12]);
      expMetric1        = METRIC_BITS'(fields[idx][13]);
      symEn             = 1'b1;
      @(posedge clk);
      #1;
      symEn = 1'b0;
      extra = $random(seed) & 1;
      repeat (3 + extra) @(posedge clk);
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycleLimit > 0 && cycles >= cycleLimit) begin
         $display("timeout after %0d cycles, the run did not finish", cycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   initial begin
      reset       = 1'b1;
      symEn       = 1'b0;
      decayFactor = '0;
      branches    = '0;
      expDecision = 1'b0;
      expPoint    = '0;
      expMetric0  = '0;
      expMetric1  = '0;
      readTestData();
      cycleLimit = nLines * 6 + 16 + 50;
      repeat (16) @(posedge clk);
      #1;
      reset = 1'b0;
      for (int i = 0; i < nLines; i++) begin
         driveSymbol(i);
      end
      repeat (6) @(posedge clk);
      if (nLines == 0) $display("no symbols were read from the test data file");
      $display("errors: %0d checker, %0d assertion; decisions seen %0d of %0d",
         errorCount, dut.checks.failCount, strobeCount, nLines);
      if (errorCount == 0 && dut.checks.failCount == 0 && nLines > 0
            && strobeCount == nLines) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== tests/trellis_testdata.txt ====
# decay re00 im00 re10 im10 re01 im01 re11 im11 | decision outRe outIm metric0 metric1
# all values hex; one line per symbol, expected columns after the four branch points
FF 1FC 001 1FC 002 1FC 003 1FC 004 1 1FC 001 07F 07F
FF 1FC 001 1FC 002 1FC 003 1FC 004 1 1FC 001 0FD 0FD
FF 1FC 001 1FC 002 1FC 003 1FC 004 1 1FC 001 17B 17B
FF 1FC 001 1FC 002 1FC 003 1FC 004 1 1FC 001 1F8 1F8
FF 1FC 001 1FC 002 1FC 003 1FC 004 1 1FC 001 275 275
FF 1FC 001 1FC 002 1FC 003 1FC 004 1 1FC 001 2F1 2F1
FF 1FC 001 1FC 002 1FC 003 1FC 004 1 1FC 001 36D 36D
FF 1FC 001 1FC 002 1FC 003 1FC 004 1 1FC 001 3E8 3E8
FF 1FC 001 1FC 002 1FC 003 1FC 004 1 1FC 001 463 463
FF 1FC 001 1FC 002 1FC 003 1FC 004 1 1FC 001 2DF 2DF
80 000 001 000 002 000 003 000 004 1 000 001 170 170
80 000 001 000 002 000 003 000 004 1 000 001 0B8 0B8
80 028 001 3B0 002 3EC 003 078 004 0 078 004 061 06B
80 338 001 310 002 298 003 284 004 1 338 001 018 006
80 000 001 050 002 008 003 004 004 0 050 002 00D 00D
60 000 001 000 002 000 003 000 004 1 000 001 005 005
FF 200 001 190 002 1FC 003 1F8 004 1 1FC 003 069 083
